//--- src/uart_line_pkg.sv
// uart line package
// character type and framing constants shared by the 8N1 serial blocks

package uart_line_pkg;

	// one serial character
	typedef logic [7:0] byte_t;

	localparam int    DATA_BITS  = 8;		// data bits per character, no parity
	localparam byte_t FRAME_MARK = 8'h26;	// '&' opens and closes a frame

endpackage

//--- src/frame_pkg.sv
// frame package
// string capacity, the string struct and the receive frame state encoding

package frame_pkg;

	localparam int MAX_CHARS = 16;						// payload capacity in bytes
	localparam int LEN_W     = $clog2(MAX_CHARS + 1);	// holds 0 to MAX_CHARS

	// a string as handed over by the host, entry 0 goes on the line first
	typedef struct packed {
		logic [LEN_W-1:0]                         len;
		uart_line_pkg::byte_t [MAX_CHARS-1:0]     chars;
	} str_t;

	// receive frame states
	typedef enum logic [1:0] {
		RX_IDLE    = 2'd0,	// hunting for the opening pair
		RX_MARK1   = 2'd1,	// first marker seen
		RX_CONTENT = 2'd2,	// collecting payload
		RX_MARK3   = 2'd3	// first closing marker seen
	} rx_state_t;

endpackage

//--- src/uart_tx.sv
// uart transmitter
// sends one byte as start bit, eight data bits lsb first and one stop bit

`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 byte_start,
	input  uart_line_pkg::byte_t byte_data,
	output logic                 uart_tx_port,
	output logic                 byte_busy,
	output logic                 byte_done
);

	localparam int CNT_W    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int LAST_BIT = uart_line_pkg::DATA_BITS + 1;	// stop bit slot
	localparam int IDX_W    = $clog2(LAST_BIT + 1);

	logic [CNT_W-1:0]                  clk_cnt;		// cycles into the current bit
	logic [IDX_W-1:0]                  bit_idx;		// 0 start, 1..8 data, 9 stop
	logic [uart_line_pkg::DATA_BITS:0] shift_reg;	// data bits then stop
	logic                              bit_end;

	assign bit_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign byte_done = byte_busy && bit_end && (bit_idx == IDX_W'(LAST_BIT));	// last stop cycle

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			byte_busy    <= 1'b0;
			uart_tx_port <= 1'b1;	// line idles high
			clk_cnt      <= '0;
			bit_idx      <= '0;
		end else if (!byte_busy) begin
			clk_cnt <= '0;
			bit_idx <= '0;
			if (byte_start) begin
				byte_busy    <= 1'b1;
				uart_tx_port <= 1'b0;	// start bit
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (bit_idx == IDX_W'(LAST_BIT)) begin
				byte_busy    <= 1'b0;
				uart_tx_port <= 1'b1;
			end else begin
				bit_idx      <= bit_idx + 1'b1;
				uart_tx_port <= shift_reg[0];
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// ones shift in behind the data, so the stop bit comes for free
	always_ff @(posedge sys_clk) begin
		if (!byte_busy && byte_start)
			shift_reg <= {1'b1, byte_data};
		else if (byte_busy && bit_end)
			shift_reg <= {1'b1, shift_reg[uart_line_pkg::DATA_BITS:1]};
	end

endmodule

//--- src/uart_rx.sv
// uart receiver
// synchronizes the line, samples each bit at mid-bit and checks the stop bit

`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 uart_rx_port,
	output uart_line_pkg::byte_t rx_byte,
	output logic                 rx_valid
);

	localparam int CNT_W    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int HALF_CNT = (CLKS_PER_BIT - 1) / 2;	// start bit recheck point
	localparam int IDX_W    = $clog2(uart_line_pkg::DATA_BITS);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} state_t;

	state_t               state;
	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;		// for falling edge detect
	logic [CNT_W-1:0]     clk_cnt;
	logic [IDX_W-1:0]     bit_cnt;
	uart_line_pkg::byte_t shift_reg;
	logic                 sample;		// mid-bit strobe

	assign sample = (state == S_START) ? (clk_cnt == CNT_W'(HALF_CNT)) :
		(clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// two-stage synchronizer
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (state == S_IDLE) begin
				clk_cnt <= '0;
				bit_cnt <= '0;
				if (rx_prev && !rx_sync)
					state <= S_START;
			end else if (!sample) begin
				clk_cnt <= clk_cnt + 1'b1;
			end else begin
				clk_cnt <= '0;
				case (state)
					S_START: state <= rx_sync ? S_IDLE : S_DATA;	// glitch, back to idle
					S_DATA: begin
						if (bit_cnt == IDX_W'(uart_line_pkg::DATA_BITS - 1))
							state <= S_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					default: begin
						state    <= S_IDLE;
						rx_valid <= rx_sync;	// framing check
					end
				endcase
			end
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && sample)
			shift_reg <= {rx_sync, shift_reg[7:1]};
		if (state == S_STOP && sample)
			rx_byte <= shift_reg;
	end

endmodule

//--- src/string_frame_ctrl.sv
// string frame control
// wraps a host string in '&&' markers for transmit and
// recovers framed strings from received bytes

`timescale 1ns/1ps

module string_frame_ctrl (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  frame_pkg::str_t      tx_string,
	input  logic                 tx_req,
	output logic                 tx_busy,
	output logic                 tx_done,
	output logic                 byte_start,
	output uart_line_pkg::byte_t byte_data,
	input  logic                 byte_busy,
	input  logic                 byte_done,
	input  uart_line_pkg::byte_t rx_byte,
	input  logic                 rx_valid,
	output frame_pkg::str_t      rx_string,
	output logic                 rx_busy,
	output logic                 rx_done
);

	localparam int LEN_W = frame_pkg::LEN_W;
	localparam int IDX_W = $clog2(frame_pkg::MAX_CHARS);
	localparam logic [LEN_W-1:0] CNT_FULL = LEN_W'(frame_pkg::MAX_CHARS);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_OPEN1,
		TX_OPEN2,
		TX_BODY,
		TX_CLOSE1,
		TX_CLOSE2
	} tx_state_t;

	//**************************************************************************
	// transmit side
	//**************************************************************************
	tx_state_t        tx_state;
	frame_pkg::str_t  tx_buf;		// captured host string
	logic [IDX_W-1:0] tx_idx;		// payload byte on the line
	logic             tx_pend;		// byte waiting for the serializer
	logic             tx_last;
	logic             tx_accept;

	assign tx_accept  = tx_req && (tx_state == TX_IDLE);	// requests while busy are dropped
	assign tx_busy    = (tx_state != TX_IDLE);
	assign byte_start = tx_pend && !byte_busy;
	assign byte_data  = (tx_state == TX_BODY) ? tx_buf.chars[tx_idx] : uart_line_pkg::FRAME_MARK;
	// also stops at capacity should the host length be out of range
	assign tx_last    = ((LEN_W'(tx_idx) + 1'b1) == tx_buf.len) ||
		(tx_idx == IDX_W'(frame_pkg::MAX_CHARS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= TX_IDLE;
			tx_idx   <= '0;
			tx_pend  <= 1'b0;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (byte_start)
				tx_pend <= 1'b0;
			case (tx_state)
				TX_IDLE: begin
					if (tx_accept) begin
						tx_state <= TX_OPEN1;
						tx_pend  <= 1'b1;
					end
				end
				TX_OPEN1: begin
					if (byte_done) begin
						tx_state <= TX_OPEN2;
						tx_pend  <= 1'b1;
					end
				end
				TX_OPEN2: begin
					if (byte_done) begin
						tx_idx   <= '0;
						tx_pend  <= 1'b1;
						tx_state <= (tx_buf.len == '0) ? TX_CLOSE1 : TX_BODY;	// empty string
					end
				end
				TX_BODY: begin
					if (byte_done) begin
						tx_pend <= 1'b1;
						if (tx_last)
							tx_state <= TX_CLOSE1;
						else
							tx_idx <= tx_idx + 1'b1;
					end
				end
				TX_CLOSE1: begin
					if (byte_done) begin
						tx_state <= TX_CLOSE2;
						tx_pend  <= 1'b1;
					end
				end
				TX_CLOSE2: begin
					if (byte_done) begin
						tx_state <= TX_IDLE;
						tx_done  <= 1'b1;
					end
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_accept)
			tx_buf <= tx_string;
	end

	//**************************************************************************
	// receive side
	//**************************************************************************
	frame_pkg::rx_state_t                             rx_state;
	uart_line_pkg::byte_t [frame_pkg::MAX_CHARS-1:0] rx_buf;		// working buffer
	logic [LEN_W-1:0]                                 rx_cnt;
	logic                                             rx_skip;		// dropped frame, eat its closing pair
	logic                                             rx_mark;
	logic                                             rx_char;

	assign rx_mark = rx_valid && (rx_byte == uart_line_pkg::FRAME_MARK);
	assign rx_char = rx_valid && (rx_byte != uart_line_pkg::FRAME_MARK);
	assign rx_busy = (rx_state != frame_pkg::RX_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state  <= frame_pkg::RX_IDLE;
			rx_cnt    <= '0;
			rx_skip   <= 1'b0;
			rx_done   <= 1'b0;
			rx_string <= '0;
		end else begin
			rx_done <= 1'b0;
			case (rx_state)
				frame_pkg::RX_IDLE: begin
					if (rx_mark)
						rx_state <= frame_pkg::RX_MARK1;
				end
				frame_pkg::RX_MARK1: begin
					if (rx_mark) begin
						// a pair while skipping ends the dropped frame
						rx_state <= rx_skip ? frame_pkg::RX_IDLE : frame_pkg::RX_CONTENT;
						rx_skip  <= 1'b0;
						rx_cnt   <= '0;
					end else if (rx_char) begin
						rx_state <= frame_pkg::RX_IDLE;
					end
				end
				frame_pkg::RX_CONTENT: begin
					if (rx_mark) begin
						rx_state <= frame_pkg::RX_MARK3;
					end else if (rx_char) begin
						if (rx_cnt == CNT_FULL) begin	// overflow
							rx_state <= frame_pkg::RX_IDLE;
							rx_skip  <= 1'b1;
						end else begin
							rx_cnt <= rx_cnt + 1'b1;
						end
					end
				end
				default: begin
					if (rx_mark) begin
						rx_string.len   <= rx_cnt;
						rx_string.chars <= rx_buf;
						rx_done         <= 1'b1;
						rx_state        <= frame_pkg::RX_IDLE;
					end else if (rx_char) begin	// lone marker in payload
						rx_state <= frame_pkg::RX_IDLE;
						rx_skip  <= 1'b1;
					end
				end
			endcase
		end
	end

	// cleared at frame start so unused entries read zero
	always_ff @(posedge sys_clk) begin
		if (rx_state == frame_pkg::RX_MARK1 && rx_mark && !rx_skip)
			rx_buf <= '0;
		else if (rx_state == frame_pkg::RX_CONTENT && rx_char && rx_cnt != CNT_FULL)
			rx_buf[rx_cnt[IDX_W-1:0]] <= rx_byte;
	end

endmodule

//--- src/uart_string_top.sv
// uart string link top
// frame control between a uart transmitter and a uart receiver

`timescale 1ns/1ps

module uart_string_top #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  frame_pkg::str_t tx_string,
	input  logic            tx_req,
	output logic            tx_busy,
	output logic            tx_done,
	output frame_pkg::str_t rx_string,
	output logic            rx_done,
	output logic            rx_busy,
	input  logic            uart_rx_port,
	output logic            uart_tx_port
);

	// byte level links
	logic                 byte_start;
	logic                 byte_busy;
	logic                 byte_done;
	uart_line_pkg::byte_t byte_data;
	uart_line_pkg::byte_t rx_byte;
	logic                 rx_valid;

	string_frame_ctrl u_ctrl (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_req     (tx_req),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_start (byte_start),
		.byte_data  (byte_data),
		.byte_busy  (byte_busy),
		.byte_done  (byte_done),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.rx_string  (rx_string),
		.rx_busy    (rx_busy),
		.rx_done    (rx_done)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_start   (byte_start),
		.byte_data    (byte_data),
		.uart_tx_port (uart_tx_port),
		.byte_busy    (byte_busy),
		.byte_done    (byte_done)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid)
	);

endmodule

//--- sim/uart_string_asserts.sv
// uart string link assertions
// strobe and frame state checks on the top level, bound from the testbench

`timescale 1ns/1ps

module uart_string_asserts (
	input logic                 sys_clk,
	input logic                 sys_rst_n,
	input logic                 tx_busy,
	input logic                 tx_done,
	input logic                 rx_busy,
	input logic                 rx_done,
	input logic                 uart_tx_port,
	input frame_pkg::rx_state_t rx_state
);

	// a frame only completes out of a busy transfer
	a_tx_done_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy))
		else $error("tx_done without tx_busy in the cycle before");

	a_tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else $error("tx_done longer than one cycle");

	a_rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done longer than one cycle");

	a_tx_line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else $error("uart_tx_port low while the transmitter is idle");

	// good frame ends from the closing marker state and leaves rx idle
	a_rx_done_close: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> (($past(rx_state) == frame_pkg::RX_MARK3) && !rx_busy))
		else $error("rx_done not out of the closing marker state");

endmodule

//--- sim/tb_uart_string.sv
// uart string link testbench
// random strings out and in, malformed frames, busy requests and full duplex

`timescale 1ns/1ps

module tb_uart_string;

	localparam int     N_BIT      = 8;		// clocks per bit
	localparam int     NUM_FRAMES = 70;		// all frames of all tests
	localparam longint TIMEOUT_NS = longint'(NUM_FRAMES) * 24 * 10 * N_BIT * 4 * 2;
	localparam int     VW         = $bits(frame_pkg::str_t);

	logic            sys_clk;
	logic            sys_rst_n;
	frame_pkg::str_t tx_string;
	logic            tx_req;
	logic            tx_busy;
	logic            tx_done;
	frame_pkg::str_t rx_string;
	logic            rx_done;
	logic            rx_busy;
	logic            uart_rx_port;
	logic            uart_tx_port;

	integer               seed;
	uart_line_pkg::byte_t exp_tx_q[$];		// bytes the tx line must show
	frame_pkg::str_t      exp_rx_q[$];		// strings rx_done must present
	int                   tx_req_cnt;
	int                   tx_done_cnt;
	int                   rx_sent_cnt;
	int                   rx_done_cnt;

	uart_string_top #(
		.CLKS_PER_BIT (N_BIT)
	) dut0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_done      (rx_done),
		.rx_busy      (rx_busy),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	bind uart_string_top uart_string_asserts u_asserts (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_tx_port (uart_tx_port),
		.rx_state     (u_ctrl.rx_state)
	);

	initial sys_clk = 1'b0;
	always #2 sys_clk = ~sys_clk;		// 4 ns period

	//**************************************************************************
	// reporting
	//**************************************************************************
	task automatic abort(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [VW-1:0] got, input logic [VW-1:0] exp);
		if (got !== exp)
			abort($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	//**************************************************************************
	// stimulus helpers
	//**************************************************************************
	task automatic rand_char(output uart_line_pkg::byte_t c);
		c = 8'($random(seed));
		if (c == uart_line_pkg::FRAME_MARK)
			c = 8'h2a;		// no marker inside a payload
	endtask

	task automatic rand_string(output frame_pkg::str_t s);
		int len;
		uart_line_pkg::byte_t c;
		len = {$random(seed)} % (frame_pkg::MAX_CHARS + 1);
		s = '0;
		s.len = frame_pkg::LEN_W'(len);
		for (int i = 0; i < len; i++) begin
			rand_char(c);
			s.chars[i] = c;
		end
	endtask

	// one 8N1 character on uart_rx_port, optionally with a low stop bit
	task automatic send_char(input uart_line_pkg::byte_t c, input logic stop_ok);
		@(negedge sys_clk);
		uart_rx_port = 1'b0;
		repeat (N_BIT) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_port = c[i];
			repeat (N_BIT) @(negedge sys_clk);
		end
		uart_rx_port = stop_ok;
		repeat (N_BIT) @(negedge sys_clk);
		uart_rx_port = 1'b1;
		if (!stop_ok)
			repeat (N_BIT) @(negedge sys_clk);
	endtask

	task automatic send_marks();
		send_char(uart_line_pkg::FRAME_MARK, 1'b1);
		send_char(uart_line_pkg::FRAME_MARK, 1'b1);
	endtask

	task automatic send_frame(input frame_pkg::str_t s);
		exp_rx_q.push_back(s);
		rx_sent_cnt++;
		send_marks();
		check("rx_busy after opening pair", rx_busy, 1'b1);
		for (int i = 0; i < int'(s.len); i++)
			send_char(s.chars[i], 1'b1);
		send_marks();
		check("rx_busy after closing pair", rx_busy, 1'b0);	// frame has ended
	endtask

	// host request, model expects '&&' payload '&&'
	task automatic send_request(input frame_pkg::str_t s);
		frame_pkg::str_t junk;
		@(negedge sys_clk);
		tx_string = s;
		tx_req    = 1'b1;
		exp_tx_q.push_back(uart_line_pkg::FRAME_MARK);
		exp_tx_q.push_back(uart_line_pkg::FRAME_MARK);
		for (int i = 0; i < int'(s.len); i++)
			exp_tx_q.push_back(s.chars[i]);
		exp_tx_q.push_back(uart_line_pkg::FRAME_MARK);
		exp_tx_q.push_back(uart_line_pkg::FRAME_MARK);
		tx_req_cnt++;
		@(negedge sys_clk);
		tx_req = 1'b0;
		rand_string(junk);
		tx_string = junk;		// host buffer reused at once
	endtask

	task automatic wait_tx_idle();
		@(negedge sys_clk);
		while (tx_busy)
			@(negedge sys_clk);
	endtask

	//**************************************************************************
	// monitors
	//**************************************************************************
	initial begin : tx_monitor
		uart_line_pkg::byte_t got;
		@(posedge sys_rst_n);
		forever begin
			@(negedge sys_clk);
			if (uart_tx_port == 1'b0) begin
				repeat (N_BIT / 2) @(negedge sys_clk);		// to mid start bit
				for (int i = 0; i < 8; i++) begin
					repeat (N_BIT) @(negedge sys_clk);
					got[i] = uart_tx_port;
				end
				repeat (N_BIT) @(negedge sys_clk);
				if (uart_tx_port !== 1'b1)
					abort("stop bit on uart_tx_port was low");
				else if (exp_tx_q.size() == 0)
					abort("byte on uart_tx_port without a pending request");
				else
					check("uart_tx_port byte", got, exp_tx_q.pop_front());
			end
		end
	end

	always @(negedge sys_clk) begin
		if (sys_rst_n && tx_done) begin
			tx_done_cnt++;
			check("tx_busy at tx_done", tx_busy, 1'b0);
			check("tx bytes left at tx_done", exp_tx_q.size(), 0);	// last stop already seen
		end
		if (sys_rst_n && rx_done) begin
			rx_done_cnt++;
			if (exp_rx_q.size() == 0)
				abort("rx_done although no valid frame was sent");
			else
				check("rx_string", rx_string, exp_rx_q.pop_front());
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		abort("timeout, the tests did not finish in time");
	end

	//**************************************************************************
	// test sequence
	//**************************************************************************
	initial begin : main
		frame_pkg::str_t      s;
		uart_line_pkg::byte_t c;
		seed         = 32'h7dea;
		sys_rst_n    = 1'b0;
		tx_req       = 1'b0;
		tx_string    = '0;
		uart_rx_port = 1'b1;
		tx_req_cnt   = 0;
		tx_done_cnt  = 0;
		rx_sent_cnt  = 0;
		rx_done_cnt  = 0;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;

		@(negedge sys_clk);
		check("tx_busy", tx_busy, 1'b0);
		check("tx_done", tx_done, 1'b0);
		check("rx_busy", rx_busy, 1'b0);
		check("rx_done", rx_done, 1'b0);
		check("uart_tx_port", uart_tx_port, 1'b1);
		check("rx_string", rx_string, '0);

		// transmit only
		for (int n = 0; n < 20; n++) begin
			rand_string(s);
			send_request(s);
			wait_tx_idle();
		end

		// receive only
		for (int n = 0; n < 20; n++) begin
			rand_string(s);
			send_frame(s);
		end

		// malformed frames, each followed by a good one
		send_char(8'h55, 1'b1);
		send_char(8'h00, 1'b1);
		rand_string(s);
		send_frame(s);
		send_char(uart_line_pkg::FRAME_MARK, 1'b1);
		send_char(8'h78, 1'b1);
		rand_string(s);
		send_frame(s);
		send_marks();		// lone marker between 'a','b' and 'c','d'
		send_char(8'h61, 1'b1);
		send_char(8'h62, 1'b1);
		send_char(uart_line_pkg::FRAME_MARK, 1'b1);
		send_char(8'h63, 1'b1);
		send_char(8'h64, 1'b1);
		send_marks();
		rand_string(s);
		send_frame(s);
		send_marks();
		for (int i = 0; i < frame_pkg::MAX_CHARS + 1; i++) begin
			rand_char(c);
			send_char(c, 1'b1);
		end
		send_marks();
		rand_string(s);
		send_frame(s);
		send_char(uart_line_pkg::FRAME_MARK, 1'b0);
		rand_string(s);
		send_frame(s);

		// second request while busy must be ignored
		rand_string(s);
		send_request(s);
		repeat (20) @(negedge sys_clk);
		check("tx_busy before second request", tx_busy, 1'b1);
		rand_string(s);
		tx_string = s;
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		wait_tx_idle();

		// full duplex
		fork
			for (int n = 0; n < 8; n++) begin
				rand_string(s);
				send_request(s);
				wait_tx_idle();
			end
			for (int n = 0; n < 8; n++) begin : rx_side
				frame_pkg::str_t r;
				rand_string(r);
				send_frame(r);
			end
		join

		repeat (4 * 10 * N_BIT) @(negedge sys_clk);
		check("tx_done count", tx_done_cnt, tx_req_cnt);
		check("tx bytes left", exp_tx_q.size(), 0);
		check("rx_done count", rx_done_cnt, rx_sent_cnt);
		check("rx strings left", exp_rx_q.size(), 0);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- project.f
src/uart_line_pkg.sv
src/frame_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/string_frame_ctrl.sv
src/uart_string_top.sv
sim/uart_string_asserts.sv
sim/tb_uart_string.sv

//--- run_sim.sh
#!/bin/sh
# build the uart string link testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_uart_string -f project.f -o sim_uart_string

./obj_dir/sim_uart_string > sim.log 2>&1 || true
cat sim.log

grep -q "^RESULT: PASS$" sim.log
